// File: ifetch_config.svh
`ifndef IFETCH_CONFIG_SVH
`define IFETCH_CONFIG_SVH

// Cache geometry, one way
`define IFETCH_IDX_LEN 8
`define IFETCH_OFS_LEN 4
`define IFETCH_TAG_LEN (32 - `IFETCH_IDX_LEN - `IFETCH_OFS_LEN)

// Words per line, refilled as one burst
`define IFETCH_LINE_WORDS 4

// VPC[31:29] of the uncached window
`define IFETCH_UNCACHED_SEG 3'b101

// Info word that travels with each pair
`define IFETCH_INFO_W 32

`endif

// File: ifetch_pkg.sv
`include "ifetch_config.svh"

package ifetch_pkg;

  typedef struct packed {
    logic [`IFETCH_TAG_LEN-1:0] tag;
    logic [`IFETCH_IDX_LEN-1:0] index;
    logic                       pair;      // Word pair within the line
    logic [`IFETCH_OFS_LEN-2:0] byte_ofs;
  } fetch_addr_s;

  // Fetch address, seen as a plain word or split for the cache
  typedef union packed {
    logic [31:0] raw;
    fetch_addr_s f;
  } fetch_addr_u;

  typedef struct packed {
    logic [1:0]                slot;     // Valid mask of the pair
    logic [31:0]               vpc;
    logic [`IFETCH_INFO_W-1:0] info;
  } fetch_req_t;

  typedef struct packed {
    logic [1:0]                slot;
    logic [31:0]               vpc;
    logic [31:0]               ppc;
    logic [1:0][31:0]          inst;
    logic [`IFETCH_INFO_W-1:0] info;
  } fetch_resp_t;

  typedef enum logic [1:0] {
    CACHEOP_INDEX_INV = 2'b00,
    CACHEOP_ALL_INV   = 2'b01,
    CACHEOP_NOP_2     = 2'b10,   // Reserved
    CACHEOP_NOP_3     = 2'b11
  } cacheop_e;

endpackage

// File: cache_bus_pkg.sv
package cache_bus_pkg;

  // Master side of the read bus
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [3:0]  burst_len;   // Beats minus one
    logic        data_ok;     // Master takes beats
  } bus_req_t;

  // Slave side
  typedef struct packed {
    logic        ready;       // Address accepted
    logic        data_ok;
    logic        data_last;
    logic [31:0] r_data;
  } bus_resp_t;

endpackage

// File: addr_map.sv
`timescale 1ns/1ps
`include "ifetch_config.svh"

module addr_map (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [31:0] vpc_i,
  input  logic        advance_i,
  output logic [31:0] ppc_o,
  output logic        uncached_o,
  output logic        paddr_valid_o
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      paddr_valid_o <= 1'b0;
    end else if (advance_i) begin
      paddr_valid_o <= 1'b1;
    end
  end

  // Fixed mapping, segment bits dropped
  always_ff @(posedge clk) begin
    if (advance_i) begin
      ppc_o      <= {3'b000, vpc_i[28:0]};
      uncached_o <= (vpc_i[31:29] == `IFETCH_UNCACHED_SEG);
    end
  end

  // F1 relies on a steady PPC while it holds
  a_ppc_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !advance_i |=> $stable(ppc_o));

endmodule

// File: icache_store.sv
`timescale 1ns/1ps
`include "ifetch_config.svh"

module icache_store (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [`IFETCH_IDX_LEN-1:0] rd_index_i,
  input  logic                       rd_pair_i,
  output logic [`IFETCH_TAG_LEN-1:0] tag_o,
  output logic                       tag_valid_o,
  output logic [1:0][31:0]           rd_data_o,
  input  logic                       wr_en_i,
  input  logic [`IFETCH_IDX_LEN:0]   wr_addr_i,
  input  logic [1:0][31:0]           wr_data_i,
  input  logic [`IFETCH_TAG_LEN-1:0] wr_tag_i,
  input  logic                       wr_last_i,
  input  logic                       inv_en_i,
  input  ifetch_pkg::cacheop_e       inv_op_i,
  input  logic [`IFETCH_IDX_LEN-1:0] inv_index_i
);

  localparam int LINES = 1 << `IFETCH_IDX_LEN;
  localparam int PAIRS = LINES * `IFETCH_LINE_WORDS / 2;

  logic [1:0][31:0]           data_mem [PAIRS];
  logic [`IFETCH_TAG_LEN-1:0] tag_mem [LINES];
  logic [LINES-1:0]           valid_q;
  logic [`IFETCH_IDX_LEN-1:0] wr_index;
  logic                       inv_covers_wr;

  assign wr_index = wr_addr_i[`IFETCH_IDX_LEN:1];

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      data_mem[wr_addr_i] <= wr_data_i;
    end
    if (wr_en_i && wr_last_i) begin
      tag_mem[wr_index] <= wr_tag_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      if (inv_en_i && inv_op_i == ifetch_pkg::CACHEOP_ALL_INV) begin
        valid_q <= '0;
      end else if (inv_en_i && inv_op_i == ifetch_pkg::CACHEOP_INDEX_INV) begin
        valid_q[inv_index_i] <= 1'b0;
      end
      // Line stays invalid until its final pair
      if (wr_en_i) begin
        valid_q[wr_index] <= wr_last_i;
      end
    end
  end

  assign tag_o       = tag_mem[rd_index_i];
  assign tag_valid_o = valid_q[rd_index_i];
  assign rd_data_o   = data_mem[{rd_index_i, rd_pair_i}];

  assign inv_covers_wr = (inv_op_i == ifetch_pkg::CACHEOP_ALL_INV) ||
                         (inv_op_i == ifetch_pkg::CACHEOP_INDEX_INV &&
                          inv_index_i == wr_index);

  // Refill writes and cache ops are sequenced apart by ifetch
  a_no_wr_inv_clash: assert property (@(posedge clk) disable iff (!rst_n)
    !(wr_en_i && inv_en_i && inv_covers_wr));

endmodule

// File: ifetch.sv
`timescale 1ns/1ps
`include "ifetch_config.svh"

module ifetch (
  input  logic                       clk,
  input  logic                       rst_n,
  input  ifetch_pkg::fetch_req_t     req_i,
  output logic                       ready_o,
  output ifetch_pkg::fetch_resp_t    resp_o,
  input  logic                       ready_i,
  input  logic                       clr_i,
  input  ifetch_pkg::cacheop_e       cacheop_i,
  input  logic                       cacheop_valid_i,
  output logic                       cacheop_ready_o,
  input  logic [31:0]                ppc_i,
  input  logic                       uncached_i,
  input  logic                       paddr_valid_i,
  output logic [`IFETCH_IDX_LEN-1:0] rd_index_o,
  output logic                       rd_pair_o,
  input  logic [`IFETCH_TAG_LEN-1:0] tag_i,
  input  logic                       tag_valid_i,
  input  logic [1:0][31:0]           rd_data_i,
  output logic                       wr_en_o,
  output logic [`IFETCH_IDX_LEN:0]   wr_addr_o,
  output logic [1:0][31:0]           wr_data_o,
  output logic [`IFETCH_TAG_LEN-1:0] wr_tag_o,
  output logic                       wr_last_o,
  output logic                       inv_en_o,
  output ifetch_pkg::cacheop_e       inv_op_o,
  output logic [`IFETCH_IDX_LEN-1:0] inv_index_o,
  output cache_bus_pkg::bus_req_t    bus_req_o,
  input  cache_bus_pkg::bus_resp_t   bus_resp_i
);

  localparam logic [7:0] S_IDLE     = 8'b0000_0001;
  localparam logic [7:0] S_COP      = 8'b0000_0010;
  localparam logic [7:0] S_RF_ADDR  = 8'b0000_0100;
  localparam logic [7:0] S_RF_DATA  = 8'b0000_1000;
  localparam logic [7:0] S_PT0_ADDR = 8'b0001_0000;
  localparam logic [7:0] S_PT0_DATA = 8'b0010_0000;
  localparam logic [7:0] S_PT1_ADDR = 8'b0100_0000;
  localparam logic [7:0] S_PT1_DATA = 8'b1000_0000;

  logic [7:0]                 state_q;
  logic [7:0]                 state_d;
  logic                       run_q;
  logic                       done_q;
  logic                       done_d;
  logic [1:0]                 f1_slot_q;
  ifetch_pkg::fetch_addr_u    f1_vpc_q;
  logic [`IFETCH_INFO_W-1:0]  f1_info_q;
  ifetch_pkg::fetch_addr_u    ppc;
  ifetch_pkg::fetch_addr_u    req_vpc;
  logic                       idle;
  logic                       f1_busy;
  logic                       hit;
  logic                       f1_done;
  logic                       beat;
  logic                       last_beat;
  logic [1:0]                 rf_beat_q;
  logic [31:0]                pair_lo_q;
  logic [1:0][31:0]           skid_q;
  ifetch_pkg::cacheop_e       cop_op_q;
  logic [`IFETCH_IDX_LEN-1:0] cop_index_q;

  assign ppc.raw     = ppc_i;
  assign req_vpc.raw = req_i.vpc;
  assign idle        = (state_q == S_IDLE);
  assign beat        = bus_resp_i.data_ok;
  assign last_beat   = bus_resp_i.data_ok && bus_resp_i.data_last;

  assign rd_index_o = f1_vpc_q.f.index;
  assign rd_pair_o  = f1_vpc_q.f.pair;
  assign hit        = tag_valid_i && (tag_i == ppc.f.tag) && !uncached_i;

  assign f1_busy = paddr_valid_i && (f1_slot_q != 2'b00);
  assign f1_done = f1_busy && (done_q || hit);   // Pair ready to leave

  assign ready_o = run_q && idle && ready_i && !clr_i && (f1_slot_q == 2'b00 || f1_done);
  assign cacheop_ready_o = idle;

  always_comb begin
    resp_o.slot = (idle && f1_done && !clr_i) ? f1_slot_q : 2'b00;
    resp_o.vpc  = f1_vpc_q.raw;
    resp_o.ppc  = ppc_i;
    resp_o.inst = done_q ? skid_q : rd_data_i;   // Skid after a bus fetch
    resp_o.info = f1_info_q;
  end

  // F1 stage
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      run_q     <= 1'b0;
      f1_slot_q <= 2'b00;
    end else begin
      run_q <= 1'b1;
      if (clr_i) begin
        f1_slot_q <= 2'b00;
      end else if (ready_o) begin
        f1_slot_q <= req_i.slot;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ready_o) begin
      f1_vpc_q.raw <= req_i.vpc;
      f1_info_q    <= req_i.info;
    end
  end

  always_comb begin
    state_d = state_q;
    done_d  = done_q && !(ready_o || clr_i);
    case (state_q)
      S_IDLE: begin
        if (cacheop_valid_i) begin
          state_d = S_COP;
        end else if (f1_busy && !done_q && !clr_i) begin
          if (uncached_i) begin
            state_d = f1_slot_q[0] ? S_PT0_ADDR : S_PT1_ADDR;
          end else if (!hit) begin
            state_d = S_RF_ADDR;
          end
        end
      end
      S_COP: state_d = S_IDLE;
      S_RF_ADDR: begin
        if (bus_resp_i.ready) begin
          state_d = S_RF_DATA;
        end
      end
      S_RF_DATA: begin
        if (last_beat) begin
          state_d = S_IDLE;
          done_d  = !clr_i;
        end
      end
      S_PT0_ADDR: begin
        if (bus_resp_i.ready) begin
          state_d = S_PT0_DATA;
        end
      end
      S_PT0_DATA: begin
        if (last_beat && f1_slot_q[1]) begin
          state_d = S_PT1_ADDR;
        end else if (last_beat) begin
          state_d = S_IDLE;
          done_d  = !clr_i;
        end
      end
      S_PT1_ADDR: begin
        if (bus_resp_i.ready) begin
          state_d = S_PT1_DATA;
        end
      end
      S_PT1_DATA: begin
        if (last_beat) begin
          state_d = S_IDLE;
          done_d  = !clr_i;
        end
      end
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q   <= S_IDLE;
      done_q    <= 1'b0;
      rf_beat_q <= 2'd0;
      wr_en_o   <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= done_d;
      wr_en_o <= 1'b0;
      if (state_q == S_RF_ADDR) begin
        rf_beat_q <= 2'd0;
      end else if (state_q == S_RF_DATA && beat) begin
        rf_beat_q <= rf_beat_q + 2'd1;
        wr_en_o   <= rf_beat_q[0];   // Pair complete
      end
    end
  end

  // Refill pairs and the skid copy of the held pair
  always_ff @(posedge clk) begin
    if (state_q == S_RF_DATA && beat) begin
      if (!rf_beat_q[0]) begin
        pair_lo_q <= bus_resp_i.r_data;
      end else begin
        wr_data_o <= {bus_resp_i.r_data, pair_lo_q};
        wr_addr_o <= {f1_vpc_q.f.index, rf_beat_q[1]};
        wr_last_o <= rf_beat_q[1];
      end
      if (rf_beat_q[1] == f1_vpc_q.f.pair) begin
        skid_q[rf_beat_q[0]] <= bus_resp_i.r_data;
      end
    end
    if (state_q == S_PT0_DATA && beat) begin
      skid_q[0] <= bus_resp_i.r_data;
    end
    if (state_q == S_PT1_DATA && beat) begin
      skid_q[1] <= bus_resp_i.r_data;
    end
  end

  assign wr_tag_o = ppc.f.tag;   // PPC still held on the last write

  always_ff @(posedge clk) begin
    if (idle && cacheop_valid_i) begin
      cop_op_q    <= cacheop_i;
      cop_index_q <= req_vpc.f.index;
    end
  end

  assign inv_en_o    = (state_q == S_COP);
  assign inv_op_o    = cop_op_q;
  assign inv_index_o = cop_index_q;

  always_comb begin
    bus_req_o.valid     = 1'b0;
    bus_req_o.addr      = {ppc.raw[31:`IFETCH_OFS_LEN], {`IFETCH_OFS_LEN{1'b0}}};
    bus_req_o.burst_len = 4'(`IFETCH_LINE_WORDS - 1);
    bus_req_o.data_ok   = 1'b0;
    if (state_q == S_RF_ADDR) begin
      bus_req_o.valid = 1'b1;
    end else if (state_q == S_PT0_ADDR || state_q == S_PT1_ADDR) begin
      bus_req_o.valid     = 1'b1;
      bus_req_o.burst_len = 4'd0;
      bus_req_o.addr      = {ppc.raw[31:3], state_q == S_PT1_ADDR, 2'b00};
    end else if (state_q == S_RF_DATA || state_q == S_PT0_DATA || state_q == S_PT1_DATA) begin
      bus_req_o.data_ok = 1'b1;
    end
  end

  a_state_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot(state_q));

  a_bus_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_o.valid && !bus_resp_i.ready |=> bus_req_o.valid && $stable(bus_req_o.addr));

endmodule

// File: ifetch_top.sv
`timescale 1ns/1ps
`include "ifetch_config.svh"

module ifetch_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  ifetch_pkg::fetch_req_t   req_i,
  output logic                     ready_o,
  output ifetch_pkg::fetch_resp_t  resp_o,
  input  logic                     ready_i,
  input  logic                     clr_i,
  input  ifetch_pkg::cacheop_e     cacheop_i,
  input  logic                     cacheop_valid_i,
  output logic                     cacheop_ready_o,
  output cache_bus_pkg::bus_req_t  bus_req_o,
  input  cache_bus_pkg::bus_resp_t bus_resp_i
);

  logic [31:0]                ppc;
  logic                       uncached;
  logic                       paddr_valid;
  logic [`IFETCH_IDX_LEN-1:0] rd_index;
  logic                       rd_pair;
  logic [`IFETCH_TAG_LEN-1:0] tag;
  logic                       tag_valid;
  logic [1:0][31:0]           rd_data;
  logic                       wr_en;
  logic [`IFETCH_IDX_LEN:0]   wr_addr;
  logic [1:0][31:0]           wr_data;
  logic [`IFETCH_TAG_LEN-1:0] wr_tag;
  logic                       wr_last;
  logic                       inv_en;
  ifetch_pkg::cacheop_e       inv_op;
  logic [`IFETCH_IDX_LEN-1:0] inv_index;

  // PPC lines up with the pair entering F1
  addr_map addr_map_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .vpc_i         (req_i.vpc),
    .advance_i     (ready_o),
    .ppc_o         (ppc),
    .uncached_o    (uncached),
    .paddr_valid_o (paddr_valid)
  );

  ifetch ifetch_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_i           (req_i),
    .ready_o         (ready_o),
    .resp_o          (resp_o),
    .ready_i         (ready_i),
    .clr_i           (clr_i),
    .cacheop_i       (cacheop_i),
    .cacheop_valid_i (cacheop_valid_i),
    .cacheop_ready_o (cacheop_ready_o),
    .ppc_i           (ppc),
    .uncached_i      (uncached),
    .paddr_valid_i   (paddr_valid),
    .rd_index_o      (rd_index),
    .rd_pair_o       (rd_pair),
    .tag_i           (tag),
    .tag_valid_i     (tag_valid),
    .rd_data_i       (rd_data),
    .wr_en_o         (wr_en),
    .wr_addr_o       (wr_addr),
    .wr_data_o       (wr_data),
    .wr_tag_o        (wr_tag),
    .wr_last_o       (wr_last),
    .inv_en_o        (inv_en),
    .inv_op_o        (inv_op),
    .inv_index_o     (inv_index),
    .bus_req_o       (bus_req_o),
    .bus_resp_i      (bus_resp_i)
  );

  icache_store icache_store_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .rd_index_i  (rd_index),
    .rd_pair_i   (rd_pair),
    .tag_o       (tag),
    .tag_valid_o (tag_valid),
    .rd_data_o   (rd_data),
    .wr_en_i     (wr_en),
    .wr_addr_i   (wr_addr),
    .wr_data_i   (wr_data),
    .wr_tag_i    (wr_tag),
    .wr_last_i   (wr_last),
    .inv_en_i    (inv_en),
    .inv_op_i    (inv_op),
    .inv_index_i (inv_index)
  );

endmodule

// File: tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int PERIOD     = 40,
  parameter int RST_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #2 rst_n_o = 1'b1;   // Released like any other input
  end

endmodule

// File: tb_bus_mem.sv
`timescale 1ns/1ps

module tb_bus_mem #(
  parameter logic [31:0] SEED = 32'h2e4f_533d
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  cache_bus_pkg::bus_req_t  bus_req_i,
  output cache_bus_pkg::bus_resp_t bus_resp_o,
  output int                       burst_cnt_o,
  output int                       single_cnt_o,
  output logic [31:0]              last_addr_o,
  output logic [3:0]               last_len_o
);

  logic [31:0] lfsr;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // Zero to three idle cycles from two LFSR bits
  task automatic random_wait();
    int n;
    n = 0;
    repeat (2) begin
      n = n * 2 + int'(lfsr[0]);
      lfsr = lfsr_next(lfsr);
    end
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  initial begin
    logic [31:0] addr;
    logic [3:0]  len;
    int          b;
    lfsr         = SEED;
    bus_resp_o   = '0;
    burst_cnt_o  = 0;
    single_cnt_o = 0;
    last_addr_o  = '0;
    last_len_o   = '0;
    forever begin
      @(posedge clk);
      #2;
      if (rst_n && bus_req_i.valid) begin
        addr        = bus_req_i.addr;
        len         = bus_req_i.burst_len;
        last_addr_o = addr;
        last_len_o  = len;
        if (len == 4'd0) single_cnt_o++;
        else burst_cnt_o++;
        random_wait();
        bus_resp_o.ready = 1'b1;
        @(posedge clk);
        #2;
        bus_resp_o.ready = 1'b0;
        for (b = 0; b <= int'(len); b++) begin
          random_wait();
          while (!bus_req_i.data_ok) begin
            @(posedge clk);
            #2;
          end
          bus_resp_o.data_ok   = 1'b1;
          bus_resp_o.data_last = (b == int'(len));
          bus_resp_o.r_data    = (addr + 32'(4 * b)) ^ 32'h5a5a_0000;   // Memory rule
          @(posedge clk);
          #2;
          bus_resp_o.data_ok   = 1'b0;
          bus_resp_o.data_last = 1'b0;
        end
      end
    end
  end

endmodule

// File: ifetch_tb.sv
`timescale 1ns/1ps

module ifetch_tb;

  localparam int     N_REQ       = 28;
  localparam longint WATCHDOG_NS = N_REQ * 200 * 40;

  logic                      clk;
  logic                      rst_n;
  ifetch_pkg::fetch_req_t    req;
  logic                      ready;
  ifetch_pkg::fetch_resp_t   resp;
  logic                      ready_in;
  logic                      clr;
  ifetch_pkg::cacheop_e      cop;
  logic                      cop_valid;
  logic                      cop_ready;
  cache_bus_pkg::bus_req_t   bus_req;
  cache_bus_pkg::bus_resp_t  bus_resp;
  int                        burst_cnt;
  int                        single_cnt;
  logic [31:0]               last_addr;
  logic [3:0]                last_len;
  logic [31:0]               lfsr;
  logic                      bp_en;
  int                        errors;
  int                        n_sent;
  int                        n_resp;
  ifetch_pkg::fetch_resp_t   exp_resp;
  ifetch_pkg::fetch_resp_t   exp_q [$];

  tb_clkgen clkgen_inst (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  ifetch_top ifetch_top_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_i           (req),
    .ready_o         (ready),
    .resp_o          (resp),
    .ready_i         (ready_in),
    .clr_i           (clr),
    .cacheop_i       (cop),
    .cacheop_valid_i (cop_valid),
    .cacheop_ready_o (cop_ready),
    .bus_req_o       (bus_req),
    .bus_resp_i      (bus_resp)
  );

  tb_bus_mem tb_bus_mem_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .bus_req_i    (bus_req),
    .bus_resp_o   (bus_resp),
    .burst_cnt_o  (burst_cnt),
    .single_cnt_o (single_cnt),
    .last_addr_o  (last_addr),
    .last_len_o   (last_len)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  // Expected pair from the address mapping and the memory rule
  function automatic ifetch_pkg::fetch_resp_t expected_resp(input ifetch_pkg::fetch_req_t r);
    ifetch_pkg::fetch_resp_t e;
    logic [31:0]             pa;
    int                      k;
    e.slot = r.slot;
    e.vpc  = r.vpc;
    e.info = r.info;
    e.ppc  = {3'b000, r.vpc[28:0]};   // Segment bits dropped
    for (k = 0; k < 2; k++) begin
      pa        = {e.ppc[31:3], (k == 1), 2'b00};
      e.inst[k] = pa ^ 32'h5a5a_0000;
    end
    return e;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] want);
    $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, want);
    errors++;
  endtask

  task automatic send_req(input logic [31:0] vpc, input logic [1:0] slot, input logic clear_it);
    req.vpc  = vpc;
    req.slot = slot;
    req.info = 32'h00f0_0000 ^ 32'(n_sent);
    n_sent++;
    do begin
      @(negedge clk);
    end while (!ready);
    if (!clear_it) exp_q.push_back(expected_resp(req));
    @(posedge clk);
    #2;
    req.slot = 2'b00;
    if (clear_it) begin
      clr = 1'b1;   // Pair now sits in F1
      @(posedge clk);
      #2;
      clr = 1'b0;
    end
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #2;
    end
    @(posedge clk);
    #2;
  endtask

  task automatic cache_op(input ifetch_pkg::cacheop_e op, input logic [31:0] vpc);
    cop       = op;
    cop_valid = 1'b1;
    req.vpc   = vpc;   // Index comes from the request VPC
    do begin
      @(negedge clk);
    end while (!cop_ready);
    @(posedge clk);
    #2;
    cop_valid = 1'b0;
  endtask

  always @(posedge clk) begin
    #2;
    ready_in = bp_en ? (take_bits(1) != 0) : 1'b1;
  end

  // Response is taken on the coming edge
  always @(negedge clk) begin
    if (rst_n && resp.slot != 2'b00 && ready_in) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected response at %0t ns with vpc %h", $time, resp.vpc);
        errors++;
      end else begin
        exp_resp = exp_q.pop_front();
        n_resp++;
        if (resp.slot !== exp_resp.slot) report_mismatch("resp_o.slot", resp.slot, exp_resp.slot);
        if (resp.vpc !== exp_resp.vpc) report_mismatch("resp_o.vpc", resp.vpc, exp_resp.vpc);
        if (resp.ppc !== exp_resp.ppc) report_mismatch("resp_o.ppc", resp.ppc, exp_resp.ppc);
        if (resp.info !== exp_resp.info) report_mismatch("resp_o.info", resp.info, exp_resp.info);
        if (exp_resp.slot[0] && resp.inst[0] !== exp_resp.inst[0])
          report_mismatch("resp_o.inst[0]", resp.inst[0], exp_resp.inst[0]);
        if (exp_resp.slot[1] && resp.inst[1] !== exp_resp.inst[1])
          report_mismatch("resp_o.inst[1]", resp.inst[1], exp_resp.inst[1]);
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns with %0d responses still pending", WATCHDOG_NS, exp_q.size());
    $display("Test failed");
    $finish;
  end

  initial begin
    int          b0;
    int          s0;
    time         t0;
    logic [31:0] rnd_vpc [12];
    logic [1:0]  rnd_slot [12];
    int          i;
    req       = '0;
    ready_in  = 1'b1;
    clr       = 1'b0;
    cop       = ifetch_pkg::CACHEOP_NOP_2;
    cop_valid = 1'b0;
    lfsr      = 32'h2e4f_533d;
    bp_en     = 1'b0;
    errors    = 0;
    n_sent    = 0;
    n_resp    = 0;
    @(posedge rst_n);
    @(posedge clk);
    #2;
    if (!cop_ready || bus_req.valid || resp.slot != 2'b00) begin
      $display("Outputs not in their reset state at %0t ns", $time);
      errors++;
    end

    // Cold line
    b0 = burst_cnt;
    send_req(32'h8000_1000, 2'b11, 1'b0);
    drain();
    if (burst_cnt != b0 + 1) report_mismatch("burst count", burst_cnt, b0 + 1);
    if (last_addr != 32'h0000_1000) report_mismatch("bus_req_o.addr", last_addr, 32'h0000_1000);
    if (last_len != 4'd3) report_mismatch("bus_req_o.burst_len", last_len, 4'd3);

    // Hits back to back
    b0 = burst_cnt;
    t0 = $time;
    send_req(32'h8000_1008, 2'b11, 1'b0);
    send_req(32'h8000_1000, 2'b10, 1'b0);
    send_req(32'h8000_1008, 2'b01, 1'b0);
    send_req(32'h8000_1000, 2'b11, 1'b0);
    if ($time - t0 != 160) report_mismatch("time for four accepts", $time - t0, 160);
    drain();
    if (burst_cnt != b0) report_mismatch("burst count", burst_cnt, b0);

    // Uncached window, then the same line cached
    b0 = burst_cnt;
    s0 = single_cnt;
    send_req(32'ha000_2000, 2'b11, 1'b0);
    send_req(32'ha000_2008, 2'b10, 1'b0);
    drain();
    if (single_cnt != s0 + 3) report_mismatch("single read count", single_cnt, s0 + 3);
    if (last_addr != 32'h0000_200c) report_mismatch("bus_req_o.addr", last_addr, 32'h0000_200c);
    if (burst_cnt != b0) report_mismatch("burst count", burst_cnt, b0);
    send_req(32'h8000_2000, 2'b11, 1'b0);
    drain();
    if (burst_cnt != b0 + 1) report_mismatch("burst count", burst_cnt, b0 + 1);

    // Random mix under back-pressure
    for (i = 0; i < 12; i++) begin
      rnd_vpc[i]  = (take_bits(1) != 0) ? 32'ha000_3000 : 32'h8000_3000;
      rnd_vpc[i]  = rnd_vpc[i] | (take_bits(2) << 4) | (take_bits(1) << 3);
      rnd_slot[i] = 2'(take_bits(2));
      if (rnd_slot[i] == 2'b00) rnd_slot[i] = 2'b11;
    end
    @(negedge clk);
    bp_en = 1'b1;
    @(posedge clk);
    #2;
    for (i = 0; i < 12; i++) begin
      send_req(rnd_vpc[i], rnd_slot[i], 1'b0);
    end
    drain();
    @(negedge clk);
    bp_en = 1'b0;
    @(posedge clk);
    #2;

    // Invalidation
    send_req(32'h8000_1000, 2'b11, 1'b0);
    send_req(32'h8000_1040, 2'b11, 1'b0);
    drain();
    cache_op(ifetch_pkg::CACHEOP_INDEX_INV, 32'h8000_1000);
    b0 = burst_cnt;
    send_req(32'h8000_1000, 2'b01, 1'b0);
    send_req(32'h8000_1040, 2'b10, 1'b0);
    drain();
    if (burst_cnt != b0 + 1) report_mismatch("burst count", burst_cnt, b0 + 1);
    if (last_addr != 32'h0000_1000) report_mismatch("bus_req_o.addr", last_addr, 32'h0000_1000);
    cache_op(ifetch_pkg::CACHEOP_ALL_INV, 32'h0000_0000);
    b0 = burst_cnt;
    send_req(32'h8000_1040, 2'b11, 1'b0);
    send_req(32'h8000_1000, 2'b11, 1'b0);
    drain();
    if (burst_cnt != b0 + 2) report_mismatch("burst count", burst_cnt, b0 + 2);

    // Clear drops the pair in F1
    b0 = burst_cnt;
    send_req(32'h8000_5000, 2'b11, 1'b1);
    repeat (4) begin
      @(posedge clk);
      #2;
    end
    if (burst_cnt != b0) report_mismatch("burst count", burst_cnt, b0);
    send_req(32'h8000_5000, 2'b11, 1'b0);
    drain();
    if (burst_cnt != b0 + 1) report_mismatch("burst count", burst_cnt, b0 + 1);

    $display("Requests %0d, responses %0d, errors %0d, bursts %0d, single reads %0d",
             n_sent, n_resp, errors, burst_cnt, single_cnt);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: ifetch_top.f
+incdir+.
ifetch_pkg.sv
cache_bus_pkg.sv
addr_map.sv
icache_store.sv
ifetch.sv
ifetch_top.sv
tb_clkgen.sv
tb_bus_mem.sv
ifetch_tb.sv

// File: Bender.yml
package:
  name: ifetch

export_include_dirs:
  - .

sources:
  - files:
      - ifetch_pkg.sv
      - cache_bus_pkg.sv
      - addr_map.sv
      - icache_store.sv
      - ifetch.sv
      - ifetch_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clkgen.sv
      - tb_bus_mem.sv
      - ifetch_tb.sv
